// File: src/memOpPkg.sv
/*
	Memory-operation bus definitions
	Operation codes, status codes and the address and tile types shared
	by the requester port and the DDR tile port.
*/

package memOpPkg;

	// byte address and the tile address above the low 4 bits
	typedef logic [31:0] memAddr_t;
	typedef logic [27:0] tileAddr_t;

	// one 128-bit tile
	typedef logic [127:0] tileData_t;

	// operation code, held on the port for the whole request
	typedef logic [4:0] opm_t;

	localparam opm_t OPM_READY   = 5'b00000;
	localparam opm_t OPM_RD_TILE = 5'b01111;
	localparam opm_t OPM_WR_TILE = 5'b10111;
	localparam opm_t OPM_FLUSH   = 5'b00110;

	// responder status
	typedef logic [1:0] okCode_t;

	// idle
	localparam okCode_t OK_READY = 2'b00;
	// done, read data valid this cycle
	localparam okCode_t OK_OK    = 2'b01;
	// busy, requester keeps its inputs
	localparam okCode_t OK_HOLD  = 2'b10;

endpackage

// File: src/l2CachePkg.sv
/*
	L2 cache geometry
	Index and epoch types, tile count and the miss-sequencer states.
*/

package l2CachePkg;

	localparam int INDEX_BITS = 8;
	localparam int TILE_COUNT = 256;

	// line index, tile address bits 7..0
	typedef logic [INDEX_BITS-1:0] tileIndex_t;

	// flush epoch, 0 is reserved for lines cleared by the sweep
	localparam int EPOCH_BITS = 4;
	typedef logic [EPOCH_BITS-1:0] epoch_t;

	// miss handling over the DDR port
	typedef enum logic [2:0] {
		IDLE,
		WB_ISSUE,
		WB_WAIT,
		FILL_ISSUE,
		FILL_WAIT,
		INSTALL
	} missState_t;

endpackage

// File: src/l2RequestDecode.sv
/*
	L2 request decode
	Registers the requester's operation unless held, splits the tile
	address into tag and index, and runs the flush epoch counter.
*/

`timescale 1ns/1ns

module l2RequestDecode (
	input  logic                  clock,
	input  logic                  reset,
	input  memOpPkg::memAddr_t    memAddr,
	input  memOpPkg::opm_t        memOpm,
	input  memOpPkg::tileData_t   memDataIn,
	input  logic                  hold,
	output memOpPkg::tileAddr_t   reqAddr,
	output l2CachePkg::tileIndex_t reqIndex,
	output memOpPkg::opm_t        reqOpm,
	output memOpPkg::tileData_t   reqData,
	output logic                  indexSettled,
	output l2CachePkg::epoch_t    epoch
);
	import memOpPkg::*;
	import l2CachePkg::*;

	tileIndex_t prevIndex;

	// request payload, frozen while the cache holds
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			reqAddr <= memAddr[31:4];
			reqData <= memDataIn;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			reqOpm <= OPM_READY;
		else if (!hold)
			reqOpm <= memOpm;
	end

	assign reqIndex = reqAddr[INDEX_BITS-1:0];

	// array output matches reqIndex once the index has stood for one edge
	always_ff @(posedge clock)
	begin
		prevIndex <= reqIndex;
	end

	assign indexSettled = (prevIndex == reqIndex);

	// epoch bumps at the capture edge of a flush, wraps past 0
	always_ff @(posedge clock)
	begin
		if (reset)
			epoch <= epoch_t'(1);
		else if (!hold && (memOpm == OPM_FLUSH))
		begin
			if (epoch == {EPOCH_BITS{1'b1}})
				epoch <= epoch_t'(1);
			else
				epoch <= epoch + epoch_t'(1);
		end
	end

endmodule

// File: src/l2TileArray.sv
/*
	L2 tile array
	Data, tag and flag storage with a registered read and one write
	port. A sweep after reset clears every line's epoch and dirty flag.
*/

`timescale 1ns/1ns

module l2TileArray (
	input  logic                   clock,
	input  logic                   reset,
	input  l2CachePkg::tileIndex_t readIndex,
	output memOpPkg::tileData_t    lineData,
	output memOpPkg::tileAddr_t    lineAddr,
	output l2CachePkg::epoch_t     lineEpoch,
	output logic                   lineDirty,
	input  logic                   storeEnable,
	input  l2CachePkg::tileIndex_t storeIndex,
	input  memOpPkg::tileData_t    storeData,
	input  memOpPkg::tileAddr_t    storeAddr,
	input  l2CachePkg::epoch_t     storeEpoch,
	input  logic                   storeDirty,
	output logic                   initBusy
);
	import memOpPkg::*;
	import l2CachePkg::*;

	tileData_t dataStore [TILE_COUNT];
	tileAddr_t addrStore [TILE_COUNT];
	logic [EPOCH_BITS:0] flagStore [TILE_COUNT];

	tileIndex_t initIndex;
	logic flagWrite;
	tileIndex_t flagIndex;
	logic [EPOCH_BITS:0] flagValue;

	// sweep owns the flag port until it finishes
	assign flagWrite = initBusy || storeEnable;
	assign flagIndex = initBusy ? initIndex : storeIndex;
	assign flagValue = initBusy ? '0 : {storeEpoch, storeDirty};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			initIndex <= '0;
			initBusy <= 1'b1;
		end
		else if (initBusy)
		begin
			initIndex <= initIndex + tileIndex_t'(1);
			if (initIndex == tileIndex_t'(TILE_COUNT - 1))
				initBusy <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (flagWrite)
			flagStore[flagIndex] <= flagValue;
		if (storeEnable && !initBusy)
		begin
			dataStore[storeIndex] <= storeData;
			addrStore[storeIndex] <= storeAddr;
		end
	end

	// read every clock, with a write to the same index forwarded
	always_ff @(posedge clock)
	begin
		if (flagWrite && (flagIndex == readIndex))
			{lineEpoch, lineDirty} <= flagValue;
		else
			{lineEpoch, lineDirty} <= flagStore[readIndex];

		if (storeEnable && !initBusy && (storeIndex == readIndex))
		begin
			lineData <= storeData;
			lineAddr <= storeAddr;
		end
		else
		begin
			lineData <= dataStore[readIndex];
			lineAddr <= addrStore[readIndex];
		end
	end

endmodule

// File: src/l2HitResolve.sv
/*
	L2 hit resolve
	Decides hit or miss for the registered request, raises hold, picks
	what goes to the store port and answers the requester.
*/

`timescale 1ns/1ns

module l2HitResolve (
	input  memOpPkg::tileAddr_t    reqAddr,
	input  l2CachePkg::tileIndex_t reqIndex,
	input  memOpPkg::opm_t         reqOpm,
	input  memOpPkg::tileData_t    reqData,
	input  logic                   indexSettled,
	input  l2CachePkg::epoch_t     epoch,
	input  memOpPkg::tileData_t    lineData,
	input  memOpPkg::tileAddr_t    lineAddr,
	input  l2CachePkg::epoch_t     lineEpoch,
	input  logic                   lineDirty,
	input  logic                   initBusy,
	input  logic                   seqBusy,
	input  logic                   fillValid,
	input  memOpPkg::tileData_t    fillData,
	output logic                   hold,
	output memOpPkg::okCode_t      memOK,
	output memOpPkg::tileData_t    memDataOut,
	output logic                   storeEnable,
	output l2CachePkg::tileIndex_t storeIndex,
	output memOpPkg::tileData_t    storeData,
	output memOpPkg::tileAddr_t    storeAddr,
	output l2CachePkg::epoch_t     storeEpoch,
	output logic                   storeDirty,
	output logic                   missStart
);
	import memOpPkg::*;

	logic isAccess;
	logic lineMiss;
	logic writeHit;

	assign isAccess = (reqOpm == OPM_RD_TILE) || (reqOpm == OPM_WR_TILE);

	// a line from an older epoch counts as absent
	assign lineMiss = (lineAddr != reqAddr) || (lineEpoch != epoch);

	always_comb
	begin
		hold = 1'b0;
		if (isAccess)
			hold = !indexSettled || lineMiss || seqBusy || initBusy || fillValid;
		else if (reqOpm == OPM_FLUSH)
			hold = initBusy;
	end

	// the sequencer reads lineDirty to decide on a writeback
	assign missStart = isAccess && indexSettled && lineMiss && !seqBusy
		&& !initBusy;

	assign writeHit = (reqOpm == OPM_WR_TILE) && !hold;

	// fill install takes priority over a write hit
	assign storeEnable = fillValid || writeHit;
	assign storeIndex = reqIndex;
	assign storeAddr = reqAddr;
	assign storeEpoch = epoch;
	assign storeData = fillValid ? fillData : reqData;
	assign storeDirty = !fillValid;

	always_comb
	begin
		if (reqOpm == OPM_READY)
			memOK = OK_READY;
		else if (hold)
			memOK = OK_HOLD;
		else
			memOK = OK_OK;
	end

	assign memDataOut = lineData;

endmodule

// File: src/l2MissSequencer.sv
/*
	L2 miss sequencer
	Writes back a dirty victim, then fetches the missing tile over the
	DDR port and hands it over for install.
*/

`timescale 1ns/1ns

module l2MissSequencer (
	input  logic                clock,
	input  logic                reset,
	input  logic                missStart,
	input  memOpPkg::tileAddr_t reqAddr,
	input  memOpPkg::tileAddr_t lineAddr,
	input  memOpPkg::tileData_t lineData,
	input  logic                lineDirty,
	output memOpPkg::memAddr_t  ddrMemAddr,
	output memOpPkg::opm_t      ddrMemOpm,
	output memOpPkg::tileData_t ddrMemDataOut,
	input  memOpPkg::tileData_t ddrMemDataIn,
	input  memOpPkg::okCode_t   ddrMemOK,
	output logic                seqBusy,
	output logic                fillValid,
	output memOpPkg::tileData_t fillData
);
	import memOpPkg::*;
	import l2CachePkg::*;

	missState_t state;

	tileAddr_t victimAddr;
	tileData_t victimData;
	tileAddr_t fetchAddr;

	logic ddrReady;
	logic ddrDone;

	assign ddrReady = (ddrMemOK == OK_READY);
	assign ddrDone = (ddrMemOK == OK_OK);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= IDLE;
			ddrMemOpm <= OPM_READY;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (missStart)
						state <= lineDirty ? WB_ISSUE : FILL_ISSUE;
				end
				WB_ISSUE:
				begin
					if (ddrReady)
					begin
						ddrMemOpm <= OPM_WR_TILE;
						state <= WB_WAIT;
					end
				end
				WB_WAIT:
				begin
					if (ddrDone)
					begin
						ddrMemOpm <= OPM_READY;
						state <= FILL_ISSUE;
					end
				end
				FILL_ISSUE:
				begin
					// previous command must be retired first
					if (ddrReady)
					begin
						ddrMemOpm <= OPM_RD_TILE;
						state <= FILL_WAIT;
					end
				end
				FILL_WAIT:
				begin
					if (ddrDone)
					begin
						ddrMemOpm <= OPM_READY;
						state <= INSTALL;
					end
				end
				INSTALL:
					state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// victim and fetch address, then DDR command payload
	always_ff @(posedge clock)
	begin
		if ((state == IDLE) && missStart)
		begin
			victimAddr <= lineAddr;
			victimData <= lineData;
			fetchAddr <= reqAddr;
		end
		if ((state == WB_ISSUE) && ddrReady)
		begin
			ddrMemAddr <= {victimAddr, 4'h0};
			ddrMemDataOut <= victimData;
		end
		if ((state == FILL_ISSUE) && ddrReady)
		begin
			ddrMemAddr <= {fetchAddr, 4'h0};
			ddrMemDataOut <= '0;
		end
		if ((state == FILL_WAIT) && ddrDone)
			fillData <= ddrMemDataIn;
	end

	assign seqBusy = (state != IDLE);
	assign fillValid = (state == INSTALL);

endmodule

// File: src/l2TileCache.sv
/*
	L2 tile cache
	Direct-mapped write-back cache of 256 tiles between a requester and
	a DDR tile port.
*/

`timescale 1ns/1ns

module l2TileCache (
	input  logic                clock,
	input  logic                reset,
	input  memOpPkg::memAddr_t  memAddr,
	input  memOpPkg::opm_t      memOpm,
	input  memOpPkg::tileData_t memDataIn,
	output memOpPkg::tileData_t memDataOut,
	output memOpPkg::okCode_t   memOK,
	output memOpPkg::memAddr_t  ddrMemAddr,
	output memOpPkg::opm_t      ddrMemOpm,
	input  memOpPkg::tileData_t ddrMemDataIn,
	output memOpPkg::tileData_t ddrMemDataOut,
	input  memOpPkg::okCode_t   ddrMemOK
);
	import memOpPkg::*;
	import l2CachePkg::*;

	// decoded request
	tileAddr_t reqAddr;
	tileIndex_t reqIndex;
	opm_t reqOpm;
	tileData_t reqData;
	logic indexSettled;
	epoch_t epoch;
	logic hold;

	// array read side
	tileData_t lineData;
	tileAddr_t lineAddr;
	epoch_t lineEpoch;
	logic lineDirty;
	logic initBusy;

	// store port
	logic storeEnable;
	tileIndex_t storeIndex;
	tileData_t storeData;
	tileAddr_t storeAddr;
	epoch_t storeEpoch;
	logic storeDirty;

	// miss handling
	logic missStart;
	logic seqBusy;
	logic fillValid;
	tileData_t fillData;

	l2RequestDecode i_requestDecode (
		.clock(clock),
		.reset(reset),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataIn(memDataIn),
		.hold(hold),
		.reqAddr(reqAddr),
		.reqIndex(reqIndex),
		.reqOpm(reqOpm),
		.reqData(reqData),
		.indexSettled(indexSettled),
		.epoch(epoch)
	);

	l2TileArray i_tileArray (
		.clock(clock),
		.reset(reset),
		.readIndex(reqIndex),
		.lineData(lineData),
		.lineAddr(lineAddr),
		.lineEpoch(lineEpoch),
		.lineDirty(lineDirty),
		.storeEnable(storeEnable),
		.storeIndex(storeIndex),
		.storeData(storeData),
		.storeAddr(storeAddr),
		.storeEpoch(storeEpoch),
		.storeDirty(storeDirty),
		.initBusy(initBusy)
	);

	l2HitResolve i_hitResolve (
		.reqAddr(reqAddr),
		.reqIndex(reqIndex),
		.reqOpm(reqOpm),
		.reqData(reqData),
		.indexSettled(indexSettled),
		.epoch(epoch),
		.lineData(lineData),
		.lineAddr(lineAddr),
		.lineEpoch(lineEpoch),
		.lineDirty(lineDirty),
		.initBusy(initBusy),
		.seqBusy(seqBusy),
		.fillValid(fillValid),
		.fillData(fillData),
		.hold(hold),
		.memOK(memOK),
		.memDataOut(memDataOut),
		.storeEnable(storeEnable),
		.storeIndex(storeIndex),
		.storeData(storeData),
		.storeAddr(storeAddr),
		.storeEpoch(storeEpoch),
		.storeDirty(storeDirty),
		.missStart(missStart)
	);

	l2MissSequencer i_missSequencer (
		.clock(clock),
		.reset(reset),
		.missStart(missStart),
		.reqAddr(reqAddr),
		.lineAddr(lineAddr),
		.lineData(lineData),
		.lineDirty(lineDirty),
		.ddrMemAddr(ddrMemAddr),
		.ddrMemOpm(ddrMemOpm),
		.ddrMemDataOut(ddrMemDataOut),
		.ddrMemDataIn(ddrMemDataIn),
		.ddrMemOK(ddrMemOK),
		.seqBusy(seqBusy),
		.fillValid(fillValid),
		.fillData(fillData)
	);

endmodule

// File: bench/l2TileCache_props.sv
/*
	L2 tile cache port properties
	DDR command stability under HOLD, no OK during the init sweep and
	an idle DDR port after reset.
*/

`timescale 1ns/1ns

module l2TileCache_props (
	input logic                clock,
	input logic                reset,
	input memOpPkg::okCode_t   memOK,
	input memOpPkg::opm_t      ddrMemOpm,
	input memOpPkg::memAddr_t  ddrMemAddr,
	input memOpPkg::tileData_t ddrMemDataOut,
	input memOpPkg::okCode_t   ddrMemOK
);
	import memOpPkg::*;
	import l2CachePkg::*;

	logic [9:0] sweepCycles;

	// cycles since reset, saturating once the sweep is over
	always_ff @(posedge clock)
	begin
		if (reset)
			sweepCycles <= '0;
		else if (sweepCycles < 10'(TILE_COUNT))
			sweepCycles <= sweepCycles + 10'd1;
	end

	ddrHoldStable: assert property (@(posedge clock) disable iff (reset)
		(ddrMemOK == OK_HOLD) |=>
		($stable(ddrMemOpm) && $stable(ddrMemAddr) && $stable(ddrMemDataOut)))
		else $error("DDR command, address or data changed while HOLD was shown");

	noOkDuringSweep: assert property (@(posedge clock) disable iff (reset)
		(sweepCycles < 10'(TILE_COUNT)) |-> (memOK != OK_OK))
		else $error("requester saw OK while the init sweep was running");

	ddrIdleAfterReset: assert property (@(posedge clock)
		reset |=> (ddrMemOpm == OPM_READY))
		else $error("DDR operation code not READY after reset");

endmodule

bind l2TileCache l2TileCache_props i_props (
	.clock(clock),
	.reset(reset),
	.memOK(memOK),
	.ddrMemOpm(ddrMemOpm),
	.ddrMemAddr(ddrMemAddr),
	.ddrMemDataOut(ddrMemDataOut),
	.ddrMemOK(ddrMemOK)
);

// File: bench/l2TileCacheTb.sv
/*
	L2 tile cache testbench
	Random reads, writes and flushes checked against a requester-side
	memory model, with a DDR responder that holds for random times.
*/

`timescale 1ns/1ns

module l2TileCacheTb;
	import memOpPkg::*;

	localparam int CLOCK_PERIOD = 40;
	localparam int OP_COUNT = 600;
	localparam int MAX_FLUSHES = 12;
	localparam int WATCHDOG_CYCLES = OP_COUNT * 400;
	localparam int unsigned RANDOM_SEED = 32'h556b_947e;

	logic clock;
	logic reset;
	memAddr_t memAddr;
	opm_t memOpm;
	tileData_t memDataIn;
	tileData_t memDataOut;
	okCode_t memOK;
	memAddr_t ddrMemAddr;
	opm_t ddrMemOpm;
	tileData_t ddrMemDataIn;
	tileData_t ddrMemDataOut;
	okCode_t ddrMemOK;

	// requester's view of memory, DDR contents, tiles accessed since the last flush
	tileData_t modelMem [tileAddr_t];
	tileData_t ddrMem [tileAddr_t];
	bit touched [tileAddr_t];

	memAddr_t pendingAddr;
	int ddrCommands = 0;
	int ddrReads = 0;
	int checkCount = 0;
	int tileErrors = 0;
	int statusErrors = 0;
	int addressErrors = 0;
	int otherErrors = 0;

	l2TileCache i_l2TileCache (
		.clock(clock),
		.reset(reset),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataIn(memDataIn),
		.memDataOut(memDataOut),
		.memOK(memOK),
		.ddrMemAddr(ddrMemAddr),
		.ddrMemOpm(ddrMemOpm),
		.ddrMemDataIn(ddrMemDataIn),
		.ddrMemDataOut(ddrMemDataOut),
		.ddrMemOK(ddrMemOK)
	);

	// untouched DDR contents built from every bit of the tile address
	function automatic tileData_t initialTile(tileAddr_t tile);
		return {4'ha, tile, 4'h5, ~tile, 4'hc, tile ^ 28'h9e3779b, 4'h3,
			{tile[13:0], tile[27:14]}};
	endfunction

	function automatic tileData_t modelTile(tileAddr_t tile);
		if (modelMem.exists(tile))
			return modelMem[tile];
		return initialTile(tile);
	endfunction

	task automatic checkTile(string what, tileData_t got, tileData_t expected);
		checkCount++;
		if (got !== expected)
		begin
			tileErrors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic checkStatus(string what, okCode_t got, okCode_t expected);
		checkCount++;
		if (got !== expected)
		begin
			statusErrors++;
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, expected);
		end
	endtask

	task automatic checkAddress(string what, memAddr_t got, memAddr_t expected);
		checkCount++;
		if (got !== expected)
		begin
			addressErrors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	initial
	begin
		clock = 1'b0;
		forever
			#(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("timeout: requester did not finish %0d operations in %0d cycles",
			OP_COUNT, WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// DDR side finishes the command it sees and checks each write-back
	task automatic completeDdr();
		tileAddr_t tile;
		tile = ddrMemAddr[31:4];
		if (ddrMemOpm == OPM_WR_TILE)
		begin
			checkAddress("write-back index", {20'h0, ddrMemAddr[11:0]},
				{20'h0, pendingAddr[11:4], 4'h0});
			checkTile("write-back data", ddrMemDataOut, modelTile(tile));
			ddrMem[tile] = ddrMemDataOut;
		end
		else if (ddrMemOpm == OPM_RD_TILE)
		begin
			checkAddress("fill address", ddrMemAddr, {pendingAddr[31:4], 4'h0});
			ddrReads++;
			ddrMemDataIn = ddrMem.exists(tile) ? ddrMem[tile] : initialTile(tile);
		end
		else
		begin
			otherErrors++;
			$display("DDR port received unknown operation code %h at %0t ns", ddrMemOpm, $time);
		end
		ddrMemOK = OK_OK;
	endtask

	initial
	begin
		int holdLeft;
		bit active;
		ddrMemOK = OK_READY;
		ddrMemDataIn = '0;
		active = 1'b0;
		holdLeft = 0;
		forever
		begin
			@(negedge clock);
			if (reset || (ddrMemOpm == OPM_READY))
			begin
				active = 1'b0;
				ddrMemOK = OK_READY;
			end
			else if (!active)
			begin
				active = 1'b1;
				ddrCommands++;
				holdLeft = $urandom_range(5, 0);
				if (holdLeft == 0)
					completeDdr();
				else
					ddrMemOK = OK_HOLD;
			end
			else if (ddrMemOK == OK_HOLD)
			begin
				holdLeft--;
				if (holdLeft == 0)
					completeDdr();
			end
		end
	end

	// inputs stay put until the falling edge that sees OK
	task automatic request(opm_t op, memAddr_t addr, tileData_t data);
		memOpm = op;
		memAddr = addr;
		memDataIn = data;
		pendingAddr = addr;
		@(negedge clock);
		while (memOK == OK_HOLD)
			@(negedge clock);
		checkStatus("request status", memOK, OK_OK);
	endtask

	task automatic idle(int cycles);
		memOpm = OPM_READY;
		repeat (cycles)
		begin
			@(negedge clock);
			checkStatus("idle status", memOK, OK_READY);
		end
	endtask

	initial
	begin
		int flushes;
		int choice;
		int readsBefore;
		int commandsBefore;
		bit haveLast;
		bit lastWasRead;
		bit isRead;
		bit expectFetch;
		bit repeatRead;
		tileAddr_t lastTile;
		tileAddr_t tile;
		memAddr_t addr;
		tileData_t data;
		logic [19:0] tagTable [4];
		void'($urandom(RANDOM_SEED));
		// four tags sharing 16 indices so that lines conflict
		tagTable[0] = 20'h00000;
		tagTable[1] = 20'h00001;
		tagTable[2] = 20'h7a3c5;
		tagTable[3] = 20'hfffff;
		flushes = 0;
		haveLast = 1'b0;
		lastWasRead = 1'b0;
		lastTile = '0;
		reset = 1'b1;
		memOpm = OPM_READY;
		memAddr = '0;
		memDataIn = '0;
		pendingAddr = '0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		for (int n = 0; n < OP_COUNT; n++)
		begin
			choice = $urandom_range(99, 0);
			if (haveLast && ($urandom_range(4, 0) == 0))
				addr = {lastTile, 4'($urandom)};
			else
				addr = {tagTable[2'($urandom)], 4'h0, 4'($urandom), 4'($urandom)};
			tile = addr[31:4];
			isRead = (choice < 45) || ((choice >= 90) && (choice % 2 == 0));
			if ((choice >= 90) && (flushes < MAX_FLUSHES))
			begin
				flushes++;
				request(OPM_FLUSH, addr, '0);
				touched.delete();
				lastWasRead = 1'b0;
			end
			else if (isRead)
			begin
				expectFetch = !touched.exists(tile);
				repeatRead = lastWasRead && (lastTile == tile);
				readsBefore = ddrReads;
				commandsBefore = ddrCommands;
				request(OPM_RD_TILE, addr, '0);
				checkTile("read data", memDataOut, modelTile(tile));
				if (expectFetch && (ddrReads == readsBefore))
				begin
					otherErrors++;
					$display("no DDR read of tile %h on its first read since a flush", tile);
				end
				if (repeatRead && (ddrCommands != commandsBefore))
				begin
					otherErrors++;
					$display("repeated read of tile %h issued a DDR command", tile);
				end
				touched[tile] = 1'b1;
				lastWasRead = 1'b1;
			end
			else
			begin
				data = {$urandom, $urandom, $urandom, $urandom};
				request(OPM_WR_TILE, addr, data);
				modelMem[tile] = data;
				touched[tile] = 1'b1;
				lastWasRead = 1'b0;
			end
			lastTile = tile;
			haveLast = 1'b1;
			if ($urandom_range(7, 0) == 0)
				idle($urandom_range(3, 1));
		end
		idle(2);

		$display("checks %0d, tile errors %0d, status errors %0d, address errors %0d, other errors %0d",
			checkCount, tileErrors, statusErrors, addressErrors, otherErrors);
		if ((tileErrors + statusErrors + addressErrors + otherErrors) == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: filelist.f
src/memOpPkg.sv
src/l2CachePkg.sv
src/l2RequestDecode.sv
src/l2TileArray.sv
src/l2HitResolve.sv
src/l2MissSequencer.sv
src/l2TileCache.sv
bench/l2TileCache_props.sv
bench/l2TileCacheTb.sv

// File: Makefile
# Verilator build and run for the L2 tile cache

VERILATOR ?= verilator
TOP ?= l2TileCacheTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_TEXT ?= TEST FAILED
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
